// File: hw/offload_pkg.sv
// --------------------
// Offload router package
// Widths, opcodes, request and response payloads and
// the pipeline options of the offload path
// --------------------
`default_nettype none

package offload_pkg;

  // Unit count must stay a power of two for the arbiter pointer wrap
  localparam int unsigned NUM_UNITS = 4;
  localparam int unsigned SEL_W     = $clog2(NUM_UNITS);
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned ID_W      = 5;
  localparam int unsigned OP_W      = 4;

  // Pipeline cuts on the offload path
  localparam bit REGISTER_OFFLOAD_REQ = 1'b1;
  localparam bit REGISTER_OFFLOAD_RSP = 1'b1;

  // Legal opcodes, values 8 to 15 are rejected by the units
  typedef enum logic [OP_W-1:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLL = 4'd5,
    OP_SRL = 4'd6,
    OP_SLT = 4'd7
  } op_e;

  // Offload request, op kept as raw bits so illegal codes pass through
  typedef struct packed {
    logic [SEL_W-1:0]  addr;
    logic [ID_W-1:0]   id;
    logic [OP_W-1:0]   op;
    logic [DATA_W-1:0] arga;
    logic [DATA_W-1:0] argb;
  } acc_req_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic              error;
  } acc_rsp_t;

endpackage

`default_nettype wire

// File: hw/offload_spill.sv
// --------------------
// Spill register for one valid/ready stream
// Two entries cut the ready and data paths, or plain wires when bypassed
// --------------------
`timescale 1ns/10ps
`default_nettype none

module offload_spill #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic a_full_q, b_full_q;
    T     a_data_q, b_data_q;
    logic a_fill, a_drain, b_fill, b_drain;

    // A takes new data, B catches A when the output stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (rst_ni) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill) begin
          a_full_q <= 1'b1;
        end else if (a_drain) begin
          a_full_q <= 1'b0;
        end
        if (b_fill) begin
          b_full_q <= 1'b1;
        end else if (b_drain) begin
          b_full_q <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) a_data_q <= data_i;
      if (b_fill) b_data_q <= a_data_q;
    end

    // B always holds the older entry
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    // Stalled output keeps its payload
    a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_ni)
      valid_o && !ready_i |=> valid_o && $stable(data_o));
  end

endmodule

`default_nettype wire

// File: hw/offload_demux.sv
// --------------------
// Request steering
// Routes valid to the unit named by the address field and
// returns that unit's ready
// --------------------
`timescale 1ns/10ps
`default_nettype none

module offload_demux (
  input  logic                                valid_i,
  output logic                                ready_o,
  input  logic [offload_pkg::SEL_W-1:0]       sel_i,
  output logic [offload_pkg::NUM_UNITS-1:0]   valid_o,
  input  logic [offload_pkg::NUM_UNITS-1:0]   ready_i
);

  // --------------------
  // Valid decode
  // --------------------
  always_comb begin
    for (int i = 0; i < offload_pkg::NUM_UNITS; i++) begin
      valid_o[i] = valid_i && (sel_i == offload_pkg::SEL_W'(i));
    end
  end

  // --------------------
  // Ready return
  // --------------------
  // Only the addressed unit may complete the handshake
  assign ready_o = ready_i[sel_i];

endmodule

`default_nettype wire

// File: hw/int_unit.sv
// --------------------
// Integer accelerator unit
// ALU ops on arga/argb with one registered result stage
// --------------------
`timescale 1ns/10ps
`default_nettype none

module int_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  offload_pkg::acc_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output offload_pkg::acc_rsp_t rsp_o,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i
);

  logic [offload_pkg::DATA_W-1:0] result;
  logic                           illegal;
  logic [4:0]                     shamt;
  logic                           accept;
  offload_pkg::acc_rsp_t          rsp_q;
  logic                           valid_q;

  assign shamt = req_i.argb[4:0];

  // --------------------
  // Operation decode
  // --------------------
  always_comb begin
    result  = '0;
    illegal = 1'b0;
    case (req_i.op)
      offload_pkg::OP_ADD: result = req_i.arga + req_i.argb;
      offload_pkg::OP_SUB: result = req_i.arga - req_i.argb;
      offload_pkg::OP_AND: result = req_i.arga & req_i.argb;
      offload_pkg::OP_OR:  result = req_i.arga | req_i.argb;
      offload_pkg::OP_XOR: result = req_i.arga ^ req_i.argb;
      offload_pkg::OP_SLL: result = req_i.arga << shamt;
      offload_pkg::OP_SRL: result = req_i.arga >> shamt;
      offload_pkg::OP_SLT: begin
        result = {{(offload_pkg::DATA_W-1){1'b0}},
                  $signed(req_i.arga) < $signed(req_i.argb)};
      end
      default: illegal = 1'b1;
    endcase
  end

  // --------------------
  // Result stage
  // --------------------
  // Accept when empty or when the held result leaves this cycle
  assign req_ready_o = !valid_q || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.id    <= req_i.id;
      rsp_q.data  <= result;
      rsp_q.error <= illegal;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = valid_q;

  // Held result is never overwritten by a new request
  a_no_overwrite: assert property (@(posedge clk_i) disable iff (rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

`default_nettype wire

// File: hw/resp_arbiter.sv
// --------------------
// Response arbiter
// Round-robin merge of the unit responses with the grant locked until transfer
// --------------------
`timescale 1ns/10ps
`default_nettype none

module resp_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  offload_pkg::acc_rsp_t [offload_pkg::NUM_UNITS-1:0]    rsp_i,
  input  logic [offload_pkg::NUM_UNITS-1:0]                     valid_i,
  output logic [offload_pkg::NUM_UNITS-1:0]                     ready_o,
  output offload_pkg::acc_rsp_t                                 rsp_o,
  output logic                                                  valid_o,
  input  logic                                                  ready_i
);

  logic [offload_pkg::SEL_W-1:0]     ptr_q, lock_idx_q, gnt_idx, rr_idx, idx;
  logic                              lock_q, found;
  logic [offload_pkg::NUM_UNITS-1:0] gnt;

  // First valid unit at or after the priority pointer
  always_comb begin
    rr_idx = '0;
    found  = 1'b0;
    idx    = '0;
    for (int i = 0; i < offload_pkg::NUM_UNITS; i++) begin
      idx = ptr_q + offload_pkg::SEL_W'(i);
      if (!found && valid_i[idx]) begin
        rr_idx = idx;
        found  = 1'b1;
      end
    end
  end

  assign gnt_idx = lock_q ? lock_idx_q : rr_idx;
  assign valid_o = lock_q || found;
  assign gnt     = valid_o ? (offload_pkg::NUM_UNITS'(1) << gnt_idx) : '0;
  assign ready_o = ready_i ? gnt : '0;
  assign rsp_o   = rsp_i[gnt_idx];

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (valid_o && ready_i) begin
      lock_q <= 1'b0;
      ptr_q  <= gnt_idx + 1'b1;
    end else if (valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

  // Stalled grant stays on the same unit
  a_gnt_locked: assert property (@(posedge clk_i) disable iff (rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(gnt));

endmodule

`default_nettype wire

// File: hw/offload_router.sv
// --------------------
// Offload router top
// Request spill, unit steering, integer units, response merge and spill
// --------------------
`timescale 1ns/10ps
`default_nettype none

module offload_router (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Request side
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic [offload_pkg::SEL_W-1:0]    req_addr_i,
  input  logic [offload_pkg::ID_W-1:0]     req_id_i,
  input  logic [offload_pkg::OP_W-1:0]     req_op_i,
  input  logic [offload_pkg::DATA_W-1:0]   req_arga_i,
  input  logic [offload_pkg::DATA_W-1:0]   req_argb_i,
  // Response side
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output logic [offload_pkg::ID_W-1:0]     rsp_id_o,
  output logic [offload_pkg::DATA_W-1:0]   rsp_data_o,
  output logic                             rsp_error_o
);

  offload_pkg::acc_req_t                             req_in, req_q;
  logic                                              req_q_valid, req_q_ready;
  logic [offload_pkg::NUM_UNITS-1:0]                 unit_req_valid, unit_req_ready;
  offload_pkg::acc_rsp_t [offload_pkg::NUM_UNITS-1:0] unit_rsp;
  logic [offload_pkg::NUM_UNITS-1:0]                 unit_rsp_valid, unit_rsp_ready;
  offload_pkg::acc_rsp_t                             arb_rsp, rsp_out;
  logic                                              arb_valid, arb_ready;

  assign req_in.addr = req_addr_i;
  assign req_in.id   = req_id_i;
  assign req_in.op   = req_op_i;
  assign req_in.arga = req_arga_i;
  assign req_in.argb = req_argb_i;

  // --------------------
  // Request path
  // --------------------
  offload_spill #(
    .T      (offload_pkg::acc_req_t),
    .Bypass (!offload_pkg::REGISTER_OFFLOAD_REQ)
  ) u_req_spill (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (req_in),
    .valid_o (req_q_valid),
    .ready_i (req_q_ready),
    .data_o  (req_q)
  );

  offload_demux u_demux (
    .valid_i (req_q_valid),
    .ready_o (req_q_ready),
    .sel_i   (req_q.addr),
    .valid_o (unit_req_valid),
    .ready_i (unit_req_ready)
  );

  // Payload fans out to every unit, only one sees valid
  for (genvar g = 0; g < offload_pkg::NUM_UNITS; g++) begin : gen_units
    int_unit u_unit (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (req_q),
      .req_valid_i (unit_req_valid[g]),
      .req_ready_o (unit_req_ready[g]),
      .rsp_o       (unit_rsp[g]),
      .rsp_valid_o (unit_rsp_valid[g]),
      .rsp_ready_i (unit_rsp_ready[g])
    );
  end

  // --------------------
  // Response path
  // --------------------
  resp_arbiter u_arbiter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rsp_i   (unit_rsp),
    .valid_i (unit_rsp_valid),
    .ready_o (unit_rsp_ready),
    .rsp_o   (arb_rsp),
    .valid_o (arb_valid),
    .ready_i (arb_ready)
  );

  offload_spill #(
    .T      (offload_pkg::acc_rsp_t),
    .Bypass (!offload_pkg::REGISTER_OFFLOAD_RSP)
  ) u_rsp_spill (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .data_i  (arb_rsp),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i),
    .data_o  (rsp_out)
  );

  assign rsp_id_o    = rsp_out.id;
  assign rsp_data_o  = rsp_out.data;
  assign rsp_error_o = rsp_out.error;

endmodule

`default_nettype wire

// File: bench/tb_offload_router.sv
// --------------------
// Offload router testbench
// Directed and random offload traffic checked against the opcode rules
// --------------------
`timescale 1ns/10ps
`default_nettype none

module tb_offload_router;

  localparam logic [31:0] SEED    = 32'd69737;
  localparam int          TIMEOUT = 200;
  localparam int          N_RAND  = 200;

  logic                             clk_i = 1'b0;
  logic                             rst_ni;
  logic                             req_valid_i, req_ready_o;
  logic [offload_pkg::SEL_W-1:0]    req_addr_i;
  logic [offload_pkg::ID_W-1:0]     req_id_i, rsp_id_o;
  logic [offload_pkg::OP_W-1:0]     req_op_i;
  logic [offload_pkg::DATA_W-1:0]   req_arga_i, req_argb_i, rsp_data_o;
  logic                             rsp_valid_o, rsp_ready_i, rsp_error_o;

  logic [31:0]                                  lfsr_q = SEED;
  logic [offload_pkg::ID_W-offload_pkg::SEL_W-1:0] seq_q = '0;
  logic [offload_pkg::NUM_UNITS-1:0]            seen_q = '0;
  logic                                         rx_done = 1'b0;
  offload_pkg::acc_rsp_t                        pending[$];

  always #4 clk_i = ~clk_i;

  offload_router u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_id_i    (req_id_i),
    .req_op_i    (req_op_i),
    .req_arga_i  (req_arga_i),
    .req_argb_i  (req_argb_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_id_o    (rsp_id_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_error_o (rsp_error_o)
  );

  // --------------------
  // Helpers
  // --------------------
  // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  // Expected {error, data} for one opcode
  function automatic logic [offload_pkg::DATA_W:0] model_op(
    input logic [offload_pkg::OP_W-1:0]   op,
    input logic [offload_pkg::DATA_W-1:0] a,
    input logic [offload_pkg::DATA_W-1:0] b
  );
    case (op)
      offload_pkg::OP_ADD: return {1'b0, a + b};
      offload_pkg::OP_SUB: return {1'b0, a - b};
      offload_pkg::OP_AND: return {1'b0, a & b};
      offload_pkg::OP_OR:  return {1'b0, a | b};
      offload_pkg::OP_XOR: return {1'b0, a ^ b};
      offload_pkg::OP_SLL: return {1'b0, a << b[4:0]};
      offload_pkg::OP_SRL: return {1'b0, a >> b[4:0]};
      offload_pkg::OP_SLT: return {1'b0, offload_pkg::DATA_W'($signed(a) < $signed(b))};
      default:             return {1'b1, {offload_pkg::DATA_W{1'b0}}};
    endcase
  endfunction

  // Id low bits carry the unit address
  task automatic send_req(
    input logic [offload_pkg::SEL_W-1:0]  addr,
    input logic [offload_pkg::OP_W-1:0]   op,
    input logic [offload_pkg::DATA_W-1:0] a,
    input logic [offload_pkg::DATA_W-1:0] b
  );
    logic [offload_pkg::DATA_W:0] exp;
    offload_pkg::acc_rsp_t        entry;
    int                           waited;
    exp         = model_op(op, a, b);
    entry.id    = {seq_q, addr};
    entry.data  = exp[offload_pkg::DATA_W-1:0];
    entry.error = exp[offload_pkg::DATA_W];
    pending.push_back(entry);
    req_addr_i  = addr;
    req_id_i    = {seq_q, addr};
    req_op_i    = op;
    req_arga_i  = a;
    req_argb_i  = b;
    req_valid_i = 1'b1;
    seq_q       = seq_q + 1'b1;
    waited      = 0;
    @(negedge clk_i);
    while (!req_ready_o) begin
      waited++;
      if (waited > TIMEOUT) abort_run("Request was never accepted by the router");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  // Oldest pending request of the same unit
  task automatic match_rsp();
    int hit;
    hit = -1;
    for (int i = 0; i < pending.size(); i++) begin
      if (hit < 0 && pending[i].id[offload_pkg::SEL_W-1:0] == rsp_id_o[offload_pkg::SEL_W-1:0])
        hit = i;
    end
    if (hit < 0) begin
      abort_run("Response arrived for a unit with no request pending");
    end else begin
      check_eq(rsp_id_o, pending[hit].id, "response id");
      check_eq(rsp_data_o, pending[hit].data, "response data");
      check_eq(rsp_error_o, pending[hit].error, "response error");
      seen_q[rsp_id_o[offload_pkg::SEL_W-1:0]] = 1'b1;
      pending.delete(hit);
    end
  endtask

  task automatic collect_rsp(input int n);
    int got;
    int idle;
    got  = 0;
    idle = 0;
    while (got < n) begin
      @(negedge clk_i);
      if (rsp_valid_o && rsp_ready_i) begin
        match_rsp();
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) abort_run("Expected response did not arrive in time");
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reset();
    check_eq(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
    check_eq(req_ready_o, 1'b1, "req_ready_o after reset");
  endtask

  // Negative operands for SLT, shift amounts with upper argb bits set
  task automatic test_all_ops();
    logic [31:0] a_set [4];
    logic [31:0] b_set [4];
    a_set = '{32'h0000_1234, 32'h8000_0005, 32'hFFFF_FFF0, 32'h7FFF_FFFF};
    b_set = '{32'hFFFF_FF00, 32'h0000_0FE3, 32'hFFFF_FFFF, 32'h8000_0021};
    for (int u = 0; u < offload_pkg::NUM_UNITS; u++) begin
      for (int op = 0; op < 8; op++) begin
        for (int k = 0; k < 4; k++) begin
          send_req(offload_pkg::SEL_W'(u), offload_pkg::OP_W'(op), a_set[k], b_set[k]);
          collect_rsp(1);
        end
      end
    end
  endtask

  task automatic test_illegal();
    for (int op = 8; op < 16; op++) begin
      send_req(offload_pkg::SEL_W'(op), offload_pkg::OP_W'(op), 32'hDEAD_BEEF, 32'h1234_5678);
      collect_rsp(1);
    end
  endtask

  task automatic test_backpressure();
    logic [offload_pkg::ID_W-1:0]   id0;
    logic [offload_pkg::DATA_W-1:0] data0;
    logic                           err0;
    int                             waited;
    rsp_ready_i = 1'b0;
    for (int i = 0; i < 8; i++) begin
      send_req(offload_pkg::SEL_W'(i), offload_pkg::OP_SUB, 32'(i * 1000 + 7), 32'(i * 3));
    end
    waited = 0;
    @(negedge clk_i);
    while (req_ready_o || !rsp_valid_o) begin
      waited++;
      if (waited > TIMEOUT) abort_run("Router never stalled its request side");
      @(negedge clk_i);
    end
    id0   = rsp_id_o;
    data0 = rsp_data_o;
    err0  = rsp_error_o;
    repeat (8) begin
      @(negedge clk_i);
      check_eq(rsp_valid_o, 1'b1, "rsp_valid_o under back-pressure");
      check_eq(rsp_id_o, id0, "rsp_id_o under back-pressure");
      check_eq(rsp_data_o, data0, "rsp_data_o under back-pressure");
      check_eq(rsp_error_o, err0, "rsp_error_o under back-pressure");
    end
    @(posedge clk_i);
    #1;
    rsp_ready_i = 1'b1;
    collect_rsp(8);
    check_eq(pending.size(), 0, "requests left without response");
    repeat (10) begin
      @(negedge clk_i);
      check_eq(rsp_valid_o, 1'b0, "rsp_valid_o after drain");
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_random();
    logic [offload_pkg::SEL_W-1:0]  addr_a [N_RAND];
    logic [offload_pkg::OP_W-1:0]   op_a   [N_RAND];
    logic [offload_pkg::DATA_W-1:0] arga_a [N_RAND];
    logic [offload_pkg::DATA_W-1:0] argb_a [N_RAND];
    logic                           ready_pat [256];
    for (int i = 0; i < N_RAND; i++) begin
      addr_a[i] = offload_pkg::SEL_W'(take_bits(2));
      op_a[i]   = offload_pkg::OP_W'(take_bits(3));
      // About one in eight is an illegal opcode
      if (take_bits(3) == 32'd0) op_a[i] = op_a[i] | 4'h8;
      arga_a[i] = take_bits(32);
      argb_a[i] = take_bits(32);
    end
    for (int i = 0; i < 256; i++) begin
      ready_pat[i] = (take_bits(2) != 32'd0);
    end
    rx_done = 1'b0;
    fork
      begin
        for (int i = 0; i < N_RAND; i++) begin
          send_req(addr_a[i], op_a[i], arga_a[i], argb_a[i]);
        end
      end
      begin
        collect_rsp(N_RAND);
        rx_done = 1'b1;
      end
      begin
        for (int c = 0; !rx_done; c++) begin
          rsp_ready_i = ready_pat[c % 256];
          @(posedge clk_i);
          #1;
        end
        rsp_ready_i = 1'b1;
      end
    join
    check_eq(pending.size(), 0, "random requests left without response");
  endtask

  // Every unit holds a second request while the response side stalls
  task automatic test_fairness();
    int waited;
    rsp_ready_i = 1'b0;
    for (int i = 0; i < 2 * offload_pkg::NUM_UNITS; i++) begin
      send_req(offload_pkg::SEL_W'(i), offload_pkg::OP_ADD, 32'(i), 32'h100);
    end
    waited = 0;
    @(negedge clk_i);
    while (req_ready_o || !rsp_valid_o) begin
      waited++;
      if (waited > TIMEOUT) abort_run("Router never stalled with every unit loaded");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    seen_q      = '0;
    rsp_ready_i = 1'b1;
    collect_rsp(offload_pkg::NUM_UNITS);
    check_eq(seen_q, {offload_pkg::NUM_UNITS{1'b1}}, "units served by the first responses");
    collect_rsp(offload_pkg::NUM_UNITS);
    check_eq(pending.size(), 0, "fairness requests left without response");
  endtask

  // --------------------
  // Sequence
  // --------------------
  initial begin
    rst_ni      = 1'b1;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_id_i    = '0;
    req_op_i    = '0;
    req_arga_i  = '0;
    req_argb_i  = '0;
    rsp_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b0;
    test_reset();
    test_all_ops();
    test_illegal();
    test_backpressure();
    test_random();
    test_fairness();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: offload_router.f
hw/offload_pkg.sv
hw/offload_spill.sv
hw/offload_demux.sv
hw/int_unit.sv
hw/resp_arbiter.sv
hw/offload_router.sv
bench/tb_offload_router.sv

// File: Makefile
# Verilator build and run for the offload router testbench

VERILATOR ?= verilator
TOP       ?= tb_offload_router
FILELIST  ?= offload_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log search decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
